//--- Makefile
# Verilator build and run of the node testbench

VERILATOR ?= verilator
TOP       ?= tb_node
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: sim clean

# Fails unless the pass line shows up in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/node_commit.sv
`timescale 1ns/10ps
`default_nettype none

module node_commit
import node_pkg::*;
(
      input  logic      i_clk
    , input  logic      i_rst
    // From execute
    , input  commit_t   i_cmt
    , input  logic      i_cmt_valid
    , output logic      o_cmt_ready
    , input  word_t     i_data_rd_data
    // Read ports for decode
    , input  reg_idx_t  i_rd_idx_a
    , input  reg_idx_t  i_rd_idx_b
    , input  reg_idx_t  i_rd_idx_c
    , output byte_t     o_rd_val_a
    , output byte_t     o_rd_val_b
    , output byte_t     o_rd_val_c
    , output byte_t     o_rd_val_7
    // Write-back, also forwarded to execute
    , output logic      o_wr_en
    , output reg_idx_t  o_wr_tgt
    , output byte_t     o_wr_val
    // Outbound messages
    , output node_msg_t o_msg
    , output logic      o_msg_valid
    , input  logic      i_msg_ready
);

byte_t regs_q [REG_COUNT];
byte_t ld_byte;

// Only a waiting SEND holds the pipe
assign o_cmt_ready = !(i_cmt_valid && i_cmt.send) || i_msg_ready;

// Read data arrives in the cycle the LOAD sits here
assign ld_byte = i_data_rd_data[{i_cmt.lane, 3'b000} +: 8];

assign o_wr_en  = i_cmt_valid && o_cmt_ready && i_cmt.wr_en;
assign o_wr_tgt = i_cmt.tgt;
assign o_wr_val = i_cmt.wr_load ? ld_byte : i_cmt.val;

// Write-through bypass
assign o_rd_val_a = (o_wr_en && o_wr_tgt == i_rd_idx_a) ? o_wr_val : regs_q[i_rd_idx_a];
assign o_rd_val_b = (o_wr_en && o_wr_tgt == i_rd_idx_b) ? o_wr_val : regs_q[i_rd_idx_b];
assign o_rd_val_c = (o_wr_en && o_wr_tgt == i_rd_idx_c) ? o_wr_val : regs_q[i_rd_idx_c];
assign o_rd_val_7 = (o_wr_en && o_wr_tgt == TRUTH_REG) ? o_wr_val : regs_q[TRUTH_REG];

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        for (int idx = 0; idx < REG_COUNT; idx++) begin
            regs_q[idx] <= '0;
        end
    end else if (o_wr_en) begin
        regs_q[o_wr_tgt] <= o_wr_val;
    end
end

assign o_msg       = i_cmt.msg;
assign o_msg_valid = i_cmt_valid && i_cmt.send;

// Execute must hold its record while the message waits
commit_msg_stable : assert property (
    @(posedge i_clk) disable iff (i_rst)
    (o_msg_valid && !i_msg_ready) |=> (o_msg_valid && $stable(o_msg))
);

endmodule : node_commit

`default_nettype wire

//--- design/node_decode.sv
`timescale 1ns/10ps
`default_nettype none

module node_decode
import node_pkg::*;
(
      input  logic     i_clk
    , input  logic     i_rst
    // From fetch
    , input  fetch_t   i_fetch
    , input  logic     i_fetch_valid
    , output logic     o_fetch_ready
    // Register file read ports
    , output reg_idx_t o_rd_idx_a
    , output reg_idx_t o_rd_idx_b
    , output reg_idx_t o_rd_idx_c
    , input  byte_t    i_rd_val_a
    , input  byte_t    i_rd_val_b
    , input  byte_t    i_rd_val_c
    , input  byte_t    i_rd_val_7
    // Pause to fetch
    , output logic     o_pause
    , output logic     o_pause_idle
    , output logic     o_pause_pc0
    , output pc_t      o_pause_pc
    // To execute
    , output decode_t  o_dec
    , output logic     o_dec_valid
    , input  logic     i_dec_ready
);

instr_t  ins;
logic    is_pause;
decode_t dec_d;
decode_t dec_q;
logic    dec_valid_q;
logic    pause_q;
logic    pause_idle_q;
logic    pause_pc0_q;
pc_t     pause_pc_q;

assign ins      = instr_t'(i_fetch.word);
assign is_pause = (ins.op == OP_PAUSE);

// Same bits hold the first register in every form
assign o_rd_idx_a = ins.body.truth.src_a;
assign o_rd_idx_b = ins.body.truth.src_b;
assign o_rd_idx_c = ins.body.truth.src_c;

always_comb begin
    dec_d.is_truth   = (ins.op == OP_TRUTH);
    dec_d.is_shuffle = (ins.op == OP_SHUFFLE);
    dec_d.is_load    = (ins.op == OP_LOAD);
    dec_d.is_store   = (ins.op == OP_STORE);
    dec_d.is_send    = (ins.op == OP_SEND);
    dec_d.idx_a      = o_rd_idx_a;
    dec_d.idx_b      = o_rd_idx_b;
    dec_d.idx_c      = o_rd_idx_c;
    dec_d.val_a      = i_rd_val_a;
    dec_d.val_b      = i_rd_val_b;
    dec_d.val_c      = i_rd_val_c;
    dec_d.val_7      = i_rd_val_7;
    // SHUFFLE and LOAD write back to their first register
    dec_d.tgt        = dec_d.is_truth ? TRUTH_REG : ins.body.truth.src_a;
    dec_d.addr       = ins.body.mem.addr;
    dec_d.body       = ins.body;
end

// Stage slot is taken by either an operation or a pending PAUSE
assign o_fetch_ready = !(dec_valid_q || pause_q) || i_dec_ready;
assign o_pause       = pause_q && i_dec_ready;

// Word behind a leaving PAUSE is discarded
always_ff @(posedge i_clk) begin
    if (i_rst) begin
        dec_valid_q <= 1'b0;
        pause_q     <= 1'b0;
    end else if (o_fetch_ready) begin
        dec_valid_q <= i_fetch_valid && !is_pause && !pause_q;
        pause_q     <= i_fetch_valid && is_pause && !pause_q;
    end
end

always_ff @(posedge i_clk) begin
    if (o_fetch_ready) begin
        dec_q        <= dec_d;
        pause_idle_q <= ins.body.pause.idle;
        pause_pc0_q  <= ins.body.pause.pc0;
        pause_pc_q   <= i_fetch.pc;
    end
end

assign o_pause_idle = pause_idle_q;
assign o_pause_pc0  = pause_pc0_q;
assign o_pause_pc   = pause_pc_q;
assign o_dec        = dec_q;
assign o_dec_valid  = dec_valid_q;

decode_single_op : assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_dec_valid |-> $onehot0({o_dec.is_truth, o_dec.is_shuffle, o_dec.is_load,
                              o_dec.is_store, o_dec.is_send})
);

endmodule : node_decode

`default_nettype wire

//--- design/node_execute.sv
`timescale 1ns/10ps
`default_nettype none

module node_execute
import node_pkg::*;
(
      input  logic                  i_clk
    , input  logic                  i_rst
    // From decode
    , input  decode_t               i_dec
    , input  logic                  i_dec_valid
    , output logic                  o_dec_ready
    // Write-back forwarded from commit
    , input  logic                  i_cmt_wr_en
    , input  reg_idx_t              i_cmt_tgt
    , input  byte_t                 i_cmt_val
    // Data RAM
    , output logic [RAM_ADDR_W-1:0] o_data_addr
    , output logic                  o_data_wr_en
    , output logic [3:0]            o_data_wr_strb
    , output word_t                 o_data_wr_data
    , output logic                  o_data_rd_en
    // To commit
    , output commit_t               o_cmt
    , output logic                  o_cmt_valid
    , input  logic                  i_cmt_ready
);

byte_t      val_a;
byte_t      val_b;
byte_t      val_c;
byte_t      val_7;
logic [2:0] truth_idx;
byte_t      res_truth;
byte_t      res_shuffle;
commit_t    cmt_d;
commit_t    cmt_q;
logic       cmt_valid_q;

// ==================================================
// Operand forwarding
// ==================================================

// Commit holds the instruction just ahead of this one
assign val_a = (i_cmt_wr_en && i_cmt_tgt == i_dec.idx_a) ? i_cmt_val : i_dec.val_a;
assign val_b = (i_cmt_wr_en && i_cmt_tgt == i_dec.idx_b) ? i_cmt_val : i_dec.val_b;
assign val_c = (i_cmt_wr_en && i_cmt_tgt == i_dec.idx_c) ? i_cmt_val : i_dec.val_c;
assign val_7 = (i_cmt_wr_en && i_cmt_tgt == TRUTH_REG) ? i_cmt_val : i_dec.val_7;

// ==================================================
// TRUTH and SHUFFLE
// ==================================================

// One picked bit per operand forms the LUT index
assign truth_idx = {
    val_c[i_dec.body.truth.sel[2]],
    val_b[i_dec.body.truth.sel[1]],
    val_a[i_dec.body.truth.sel[0]]
};
assign res_truth = {val_7[6:0], i_dec.body.truth.lut[truth_idx]};

always_comb begin
    for (int n = 0; n < 8; n++) begin
        res_shuffle[n] = val_a[i_dec.body.shuffle.sel[n]];
    end
end

// ==================================================
// Data RAM access
// ==================================================

assign o_dec_ready    = !cmt_valid_q || i_cmt_ready;
assign o_data_addr    = i_dec.addr[9:2];
// Held LOAD reads again while STORE writes only on transfer
assign o_data_rd_en   = i_dec_valid && i_dec.is_load;
assign o_data_wr_en   = i_dec_valid && i_dec.is_store && o_dec_ready;
assign o_data_wr_strb = 4'b0001 << i_dec.addr[1:0];
assign o_data_wr_data = {4{val_a}};

// Commit record
always_comb begin
    cmt_d.wr_en     = i_dec.is_truth || i_dec.is_shuffle || i_dec.is_load;
    cmt_d.wr_load   = i_dec.is_load;
    cmt_d.tgt       = i_dec.tgt;
    cmt_d.val       = i_dec.is_truth ? res_truth : res_shuffle;
    cmt_d.lane      = i_dec.addr[1:0];
    cmt_d.send      = i_dec.is_send;
    cmt_d.msg.node  = i_dec.body.mem.node;
    cmt_d.msg.addr  = i_dec.addr;
    cmt_d.msg.data  = val_a;
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        cmt_valid_q <= 1'b0;
    end else if (o_dec_ready) begin
        cmt_valid_q <= i_dec_valid;
    end
end

// Held under stall so a waiting message stays put
always_ff @(posedge i_clk) begin
    if (o_dec_ready) begin
        cmt_q <= cmt_d;
    end
end

assign o_cmt       = cmt_q;
assign o_cmt_valid = cmt_valid_q;

endmodule : node_execute

`default_nettype wire

//--- design/node_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module node_fetch
import node_pkg::*;
(
      input  logic   i_clk
    , input  logic   i_rst
    // Control
    , input  logic   i_trigger
    , output logic   o_idle
    // Pause request from decode
    , input  logic   i_pause
    , input  logic   i_pause_idle
    , input  logic   i_pause_pc0
    , input  pc_t    i_pause_pc
    // Instruction RAM
    , output pc_t    o_inst_addr
    , output logic   o_inst_rd_en
    , input  word_t  i_inst_rd_data
    // To decode
    , output fetch_t o_fetch
    , output logic   o_fetch_valid
    , input  logic   i_fetch_ready
);

logic pause_q;
logic idle_q;
logic valid_q;
// Next address to read
pc_t  pc_q;
// Address of the word now on the RAM output
pc_t  fetch_pc_q;
logic stall;

// Held word is read again so the RAM output stays current
assign stall        = valid_q && !i_fetch_ready;
assign o_inst_rd_en = !pause_q && !i_pause;
assign o_inst_addr  = stall ? fetch_pc_q : pc_q;

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        pause_q <= 1'b1;
        idle_q  <= 1'b1;
        valid_q <= 1'b0;
        pc_q    <= '0;
    end else if (i_pause) begin
        // Younger word in flight is dropped
        pause_q <= 1'b1;
        idle_q  <= i_pause_idle;
        valid_q <= 1'b0;
        pc_q    <= i_pause_pc0 ? '0 : (i_pause_pc + pc_t'(1));
    end else if (pause_q) begin
        if (i_trigger) begin
            pause_q <= 1'b0;
            idle_q  <= 1'b0;
        end
    end else if (!stall) begin
        valid_q <= 1'b1;
        pc_q    <= pc_q + pc_t'(1);
    end
end

always_ff @(posedge i_clk) begin
    if (o_inst_rd_en && !stall) begin
        fetch_pc_q <= pc_q;
    end
end

assign o_idle        = idle_q;
assign o_fetch.word  = i_inst_rd_data;
assign o_fetch.pc    = fetch_pc_q;
assign o_fetch_valid = valid_q;

// Instruction RAM stays free for the host until a trigger
fetch_no_read_paused : assert property (
    @(posedge i_clk) disable iff (i_rst)
    (pause_q && !i_trigger) |=> !o_inst_rd_en
);

endmodule : node_fetch

`default_nettype wire

//--- design/node_pkg.sv
`default_nettype none

package node_pkg;

// ==================================================
// Widths and constants
// ==================================================

localparam REG_COUNT  = 8;
localparam REG_IDX_W  = 3;
localparam RAM_ADDR_W = 8;

typedef logic [REG_IDX_W-1:0]  reg_idx_t;
typedef logic [7:0]            byte_t;
typedef logic [31:0]           word_t;
typedef logic [RAM_ADDR_W-1:0] pc_t;
// Upper 8 bits pick the word and lower 2 bits the byte lane
typedef logic [9:0]            data_addr_t;

// TRUTH always shifts into the top register
localparam reg_idx_t TRUTH_REG = reg_idx_t'(REG_COUNT - 1);

typedef struct packed {
    logic [3:0] row;
    logic [3:0] col;
} node_id_t;

// ==================================================
// Instruction encoding
// ==================================================

typedef enum logic [2:0] {
    OP_PAUSE   = 3'd0,
    OP_TRUTH   = 3'd1,
    OP_SHUFFLE = 3'd2,
    OP_LOAD    = 3'd3,
    OP_STORE   = 3'd4,
    OP_SEND    = 3'd5
} opcode_e;

// Every form keeps its first register index at the same bits
typedef struct packed {
    reg_idx_t        src_a;
    reg_idx_t        src_b;
    reg_idx_t        src_c;
    logic [2:0][2:0] sel;
    byte_t           lut;
    logic [2:0]      pad;
} truth_t;

typedef struct packed {
    reg_idx_t        src_a;
    logic [7:0][2:0] sel;
    logic [1:0]      pad;
} shuffle_t;

// LOAD target, STORE and SEND source
typedef struct packed {
    reg_idx_t   data_reg;
    data_addr_t addr;
    node_id_t   node;
    logic [7:0] pad;
} memory_t;

typedef struct packed {
    logic        idle;
    logic        pc0;
    logic [26:0] pad;
} pause_t;

typedef union packed {
    truth_t   truth;
    shuffle_t shuffle;
    memory_t  mem;
    pause_t   pause;
} instr_body_t;

typedef struct packed {
    opcode_e     op;
    instr_body_t body;
} instr_t;

// ==================================================
// Stage links
// ==================================================

typedef struct packed {
    node_id_t   node;
    data_addr_t addr;
    byte_t      data;
} node_msg_t;

typedef struct packed {
    word_t word;
    pc_t   pc;
} fetch_t;

typedef struct packed {
    // One-hot operation flags since PAUSE never leaves decode
    logic        is_truth;
    logic        is_shuffle;
    logic        is_load;
    logic        is_store;
    logic        is_send;
    reg_idx_t    idx_a;
    reg_idx_t    idx_b;
    reg_idx_t    idx_c;
    byte_t       val_a;
    byte_t       val_b;
    byte_t       val_c;
    byte_t       val_7;
    reg_idx_t    tgt;
    data_addr_t  addr;
    // Bit selects, LUT and send target
    instr_body_t body;
} decode_t;

typedef struct packed {
    logic       wr_en;
    // Write-back from RAM read data rather than the result
    logic       wr_load;
    reg_idx_t   tgt;
    byte_t      val;
    logic [1:0] lane;
    logic       send;
    node_msg_t  msg;
} commit_t;

endpackage : node_pkg

`default_nettype wire

//--- design/node_ram.sv
`timescale 1ns/10ps
`default_nettype none

module node_ram
import node_pkg::*;
#(
    parameter int DEPTH_W = RAM_ADDR_W
) (
      input  logic               i_clk
    , input  logic               i_wr_en
    , input  logic [3:0]         i_wr_strb
    , input  logic [DEPTH_W-1:0] i_addr
    , input  word_t              i_wr_data
    , input  logic               i_rd_en
    , output word_t              o_rd_data
);

word_t mem_q [2**DEPTH_W];

// Byte lanes written independently
always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (i_wr_strb[lane]) begin
                mem_q[i_addr][lane*8 +: 8] <= i_wr_data[lane*8 +: 8];
            end
        end
    end
end

// Output register holds its word while not enabled
always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
        o_rd_data <= mem_q[i_addr];
    end
end

endmodule : node_ram

`default_nettype wire

//--- design/node_top.sv
`timescale 1ns/10ps
`default_nettype none

module node_top
import node_pkg::*;
(
      input  logic      i_clk
    , input  logic      i_rst
    // Control
    , input  logic      i_trigger
    , output logic      o_idle
    // Host instruction load
    , input  logic      i_load_valid
    , input  pc_t       i_load_addr
    , input  word_t     i_load_data
    // Outbound messages
    , output node_msg_t o_msg
    , output logic      o_msg_valid
    , input  logic      i_msg_ready
);

// ==================================================
// Interconnect
// ==================================================

pc_t      inst_addr;
pc_t      inst_ram_addr;
logic     inst_rd_en;
word_t    inst_rd_data;
logic     load_wr;
fetch_t   fetch;
logic     fetch_valid;
logic     fetch_ready;
reg_idx_t rd_idx_a;
reg_idx_t rd_idx_b;
reg_idx_t rd_idx_c;
byte_t    rd_val_a;
byte_t    rd_val_b;
byte_t    rd_val_c;
byte_t    rd_val_7;
logic     pause;
logic     pause_idle;
logic     pause_pc0;
pc_t      pause_pc;
decode_t  dec;
logic     dec_valid;
logic     dec_ready;
logic     wr_en;
reg_idx_t wr_tgt;
byte_t    wr_val;
logic [RAM_ADDR_W-1:0] data_addr;
logic                  data_wr_en;
logic [3:0]            data_wr_strb;
word_t                 data_wr_data;
logic                  data_rd_en;
word_t                 data_rd_data;
commit_t  cmt;
logic     cmt_valid;
logic     cmt_ready;

// Host writes only while idle when the core never reads
assign load_wr       = i_load_valid && o_idle;
assign inst_ram_addr = load_wr ? i_load_addr : inst_addr;

// ==================================================
// Pipeline stages
// ==================================================

node_fetch u_fetch (
      .i_clk(i_clk), .i_rst(i_rst)
    , .i_trigger(i_trigger), .o_idle(o_idle)
    , .i_pause(pause), .i_pause_idle(pause_idle)
    , .i_pause_pc0(pause_pc0), .i_pause_pc(pause_pc)
    , .o_inst_addr(inst_addr), .o_inst_rd_en(inst_rd_en)
    , .i_inst_rd_data(inst_rd_data)
    , .o_fetch(fetch), .o_fetch_valid(fetch_valid), .i_fetch_ready(fetch_ready)
);

node_decode u_decode (
      .i_clk(i_clk), .i_rst(i_rst)
    , .i_fetch(fetch), .i_fetch_valid(fetch_valid), .o_fetch_ready(fetch_ready)
    , .o_rd_idx_a(rd_idx_a), .o_rd_idx_b(rd_idx_b), .o_rd_idx_c(rd_idx_c)
    , .i_rd_val_a(rd_val_a), .i_rd_val_b(rd_val_b)
    , .i_rd_val_c(rd_val_c), .i_rd_val_7(rd_val_7)
    , .o_pause(pause), .o_pause_idle(pause_idle)
    , .o_pause_pc0(pause_pc0), .o_pause_pc(pause_pc)
    , .o_dec(dec), .o_dec_valid(dec_valid), .i_dec_ready(dec_ready)
);

node_execute u_execute (
      .i_clk(i_clk), .i_rst(i_rst)
    , .i_dec(dec), .i_dec_valid(dec_valid), .o_dec_ready(dec_ready)
    , .i_cmt_wr_en(wr_en), .i_cmt_tgt(wr_tgt), .i_cmt_val(wr_val)
    , .o_data_addr(data_addr), .o_data_wr_en(data_wr_en)
    , .o_data_wr_strb(data_wr_strb), .o_data_wr_data(data_wr_data)
    , .o_data_rd_en(data_rd_en)
    , .o_cmt(cmt), .o_cmt_valid(cmt_valid), .i_cmt_ready(cmt_ready)
);

node_commit u_commit (
      .i_clk(i_clk), .i_rst(i_rst)
    , .i_cmt(cmt), .i_cmt_valid(cmt_valid), .o_cmt_ready(cmt_ready)
    , .i_data_rd_data(data_rd_data)
    , .i_rd_idx_a(rd_idx_a), .i_rd_idx_b(rd_idx_b), .i_rd_idx_c(rd_idx_c)
    , .o_rd_val_a(rd_val_a), .o_rd_val_b(rd_val_b)
    , .o_rd_val_c(rd_val_c), .o_rd_val_7(rd_val_7)
    , .o_wr_en(wr_en), .o_wr_tgt(wr_tgt), .o_wr_val(wr_val)
    , .o_msg(o_msg), .o_msg_valid(o_msg_valid), .i_msg_ready(i_msg_ready)
);

// ==================================================
// Memories
// ==================================================

node_ram #(.DEPTH_W($bits(pc_t))) u_inst_ram (
      .i_clk(i_clk)
    , .i_wr_en(load_wr), .i_wr_strb(4'b1111)
    , .i_addr(inst_ram_addr), .i_wr_data(i_load_data)
    , .i_rd_en(inst_rd_en), .o_rd_data(inst_rd_data)
);

node_ram #(.DEPTH_W(RAM_ADDR_W)) u_data_ram (
      .i_clk(i_clk)
    , .i_wr_en(data_wr_en), .i_wr_strb(data_wr_strb)
    , .i_addr(data_addr), .i_wr_data(data_wr_data)
    , .i_rd_en(data_rd_en), .o_rd_data(data_rd_data)
);

endmodule : node_top

`default_nettype wire

//--- verification/tb_node.sv
`timescale 1ns/10ps
`default_nettype none

module tb_node
import node_pkg::*;
();

localparam int CLK_PERIOD = 100;
localparam int WAIT_LIMIT = 5000;
localparam int PROG_COUNT = 8;

logic      i_clk;
logic      i_rst;
logic      i_trigger;
logic      o_idle;
logic      i_load_valid;
pc_t       i_load_addr;
word_t     i_load_data;
node_msg_t o_msg;
logic      o_msg_valid;
logic      i_msg_ready;

integer    seed = 32'hdf4d86e3;
logic      ready_random;
logic      timed_out;
int        msg_errors = 0;
int        idle_errors = 0;
int        misc_errors = 0;
int        exp_total = 0;
int        got_total = 0;

// Expected messages, oldest first
node_msg_t  exp_q [$];
// Program image as loaded into instruction RAM
word_t      prog [256];
int         prog_len;
// Byte addresses this program has written and may LOAD
data_addr_t stored_q [$];

// ISA model state
byte_t      regs_m [REG_COUNT];
byte_t      mem_m [1024];
pc_t        pc_m;

node_top uut (
      .i_clk(i_clk), .i_rst(i_rst)
    , .i_trigger(i_trigger), .o_idle(o_idle)
    , .i_load_valid(i_load_valid), .i_load_addr(i_load_addr), .i_load_data(i_load_data)
    , .o_msg(o_msg), .o_msg_valid(o_msg_valid), .i_msg_ready(i_msg_ready)
);

// ==================================================
// Clock, message sink and monitor
// ==================================================

initial begin
    i_clk = 1'b0;
    forever begin
        #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end
end

// Sink ready is either always high or a coin flip per cycle
initial begin
    i_msg_ready = 1'b1;
    forever begin
        @(posedge i_clk);
        #1;
        i_msg_ready = ready_random ? 1'($random(seed)) : 1'b1;
    end
end

// Handshake sampled mid-cycle where both sides are settled
always @(negedge i_clk) begin
    if (o_msg_valid && i_msg_ready) begin
        if (exp_q.size() == 0) begin
            $display("Message %h arrived with none expected", o_msg);
            msg_errors++;
        end else begin
            check_msg(o_msg, exp_q.pop_front());
        end
        got_total++;
    end
end

// ==================================================
// Helpers
// ==================================================

task automatic next_cycle();
    @(posedge i_clk);
    #1;
endtask

task automatic check_msg(input node_msg_t got, input node_msg_t exp);
    if (got !== exp) begin
        $display("Fail o_msg: got %h expected %h", got, exp);
        msg_errors++;
    end
endtask

task automatic check_idle(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Fail %s: got %h expected %h", name, got, exp);
        idle_errors++;
    end
endtask

function automatic int unsigned rnd(input int unsigned range);
    return $unsigned($random(seed)) % range;
endfunction

// Random word with the fields that matter forced
function automatic word_t make_instr(input opcode_e op, input reg_idx_t r,
                                     input data_addr_t addr, input logic idle,
                                     input logic pc0);
    instr_t ins;
    ins    = instr_t'($random(seed));
    ins.op = op;
    case (op)
        OP_PAUSE: begin
            ins.body.pause.idle = idle;
            ins.body.pause.pc0  = pc0;
        end
        OP_TRUTH, OP_SHUFFLE: ins.body.truth.src_a = r;
        default: begin
            ins.body.mem.data_reg = r;
            ins.body.mem.addr     = addr;
        end
    endcase
    return word_t'(ins);
endfunction

function automatic void add_word(input word_t w);
    prog[prog_len] = w;
    prog_len++;
endfunction

// Groups of dependent ops each closed by a SEND of its last target
task automatic gen_program(input logic use_mem, input logic mid_pause);
    int         groups;
    int         len;
    reg_idx_t   tgt;
    data_addr_t addr;
    stored_q.delete();
    prog_len = 0;
    groups   = 6 + int'(rnd(6));
    for (int g = 0; g < groups; g++) begin
        if (mid_pause && g == groups / 2) begin
            add_word(make_instr(OP_PAUSE, '0, '0, 1'b0, 1'b0));
        end
        tgt = reg_idx_t'(rnd(8));
        len = 1 + int'(rnd(3));
        for (int k = 0; k < len; k++) begin
            if (use_mem && rnd(2) == 0) begin
                if (stored_q.size() > 0 && rnd(2) == 0) begin
                    // Often the newest byte to hit STORE right before LOAD
                    addr = (rnd(2) == 0) ? stored_q[$] : stored_q[rnd(stored_q.size())];
                    add_word(make_instr(OP_LOAD, tgt, addr, 1'b0, 1'b0));
                end else begin
                    addr = data_addr_t'(rnd(1024));
                    stored_q.push_back(addr);
                    add_word(make_instr(OP_STORE, tgt, addr, 1'b0, 1'b0));
                end
            end else if (rnd(2) == 0) begin
                add_word(make_instr(OP_TRUTH, tgt, '0, 1'b0, 1'b0));
                tgt = 3'd7;
            end else begin
                add_word(make_instr(OP_SHUFFLE, tgt, '0, 1'b0, 1'b0));
            end
        end
        add_word(make_instr(OP_SEND, tgt, data_addr_t'(rnd(1024)), 1'b0, 1'b0));
    end
    // Idle stop that rewinds so the next program starts at zero
    add_word(make_instr(OP_PAUSE, '0, '0, 1'b1, 1'b1));
endtask

// ==================================================
// ISA model
// ==================================================

// Runs from pc_m up to the next PAUSE and queues every SEND
task automatic run_model(output logic stop_idle);
    instr_t     ins;
    byte_t      tmp;
    logic [2:0] idx;
    node_msg_t  msg;
    stop_idle = 1'b1;
    for (int step = 0; step < 256; step++) begin
        ins = instr_t'(prog[pc_m]);
        case (ins.op)
            OP_PAUSE: begin
                stop_idle = ins.body.pause.idle;
                pc_m      = ins.body.pause.pc0 ? '0 : pc_m + pc_t'(1);
                return;
            end
            OP_TRUTH: begin
                idx = {regs_m[ins.body.truth.src_c][ins.body.truth.sel[2]],
                       regs_m[ins.body.truth.src_b][ins.body.truth.sel[1]],
                       regs_m[ins.body.truth.src_a][ins.body.truth.sel[0]]};
                regs_m[7] = {regs_m[7][6:0], ins.body.truth.lut[idx]};
            end
            OP_SHUFFLE: begin
                for (int n = 0; n < 8; n++) begin
                    tmp[n] = regs_m[ins.body.shuffle.src_a][ins.body.shuffle.sel[n]];
                end
                regs_m[ins.body.shuffle.src_a] = tmp;
            end
            OP_LOAD: regs_m[ins.body.mem.data_reg] = mem_m[ins.body.mem.addr];
            OP_STORE: mem_m[ins.body.mem.addr] = regs_m[ins.body.mem.data_reg];
            OP_SEND: begin
                msg.node = ins.body.mem.node;
                msg.addr = ins.body.mem.addr;
                msg.data = regs_m[ins.body.mem.data_reg];
                exp_q.push_back(msg);
                exp_total++;
            end
            default: ;
        endcase
        pc_m = pc_m + pc_t'(1);
    end
endtask

// ==================================================
// Host load and run control
// ==================================================

task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
        i_load_valid = 1'b1;
        i_load_addr  = pc_t'(i);
        i_load_data  = prog[i];
        next_cycle();
    end
    i_load_valid = 1'b0;
endtask

// One trigger up to the next PAUSE
task automatic run_segment();
    logic stop_idle;
    int   cycles;
    if (timed_out) begin
        return;
    end
    run_model(stop_idle);
    i_trigger = 1'b1;
    next_cycle();
    i_trigger = 1'b0;
    // Trigger clears idle long before the PAUSE can come back
    check_idle("o_idle", o_idle, 1'b0);
    cycles = 0;
    while (got_total != exp_total && cycles < WAIT_LIMIT) begin
        next_cycle();
        cycles++;
    end
    if (got_total != exp_total) begin
        $display("Timeout: %0d messages expected, %0d arrived", exp_total, got_total);
        misc_errors++;
        timed_out = 1'b1;
        return;
    end
    if (stop_idle) begin
        cycles = 0;
        while (!o_idle && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (!o_idle) begin
            $display("Timeout: core never went idle after its PAUSE");
            misc_errors++;
            timed_out = 1'b1;
        end
    end else begin
        // Paused but not idle so any stray message shows up in the monitor
        repeat (10) next_cycle();
        check_idle("o_idle", o_idle, 1'b0);
    end
endtask

// ==================================================
// Test sequence
// ==================================================

initial begin
    int passes;
    i_rst        = 1'b1;
    i_trigger    = 1'b0;
    i_load_valid = 1'b0;
    i_load_addr  = '0;
    i_load_data  = '0;
    ready_random = 1'b0;
    timed_out    = 1'b0;
    pc_m         = '0;
    for (int r = 0; r < REG_COUNT; r++) begin
        regs_m[r] = '0;
    end
    repeat (10) next_cycle();
    i_rst = 1'b0;
    next_cycle();
    check_idle("o_idle", o_idle, 1'b1);
    check_idle("o_msg_valid", o_msg_valid, 1'b0);

    // Chains first, then memory, then random sink, then mid-program pauses
    for (int p = 0; p < PROG_COUNT && !timed_out; p++) begin
        ready_random = (p >= 4);
        gen_program(p >= 2, p >= 6);
        load_program();
        // Last program runs twice to replay from zero
        passes = (p == PROG_COUNT - 1) ? 2 : 1;
        for (int pass = 0; pass < passes; pass++) begin
            run_segment();
            if (p >= 6) begin
                run_segment();
            end
        end
    end

    $display("Errors: message %0d, idle %0d, other %0d", msg_errors, idle_errors, misc_errors);
    if (msg_errors + idle_errors + misc_errors == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

endmodule : tb_node

`default_nettype wire

//--- verilog.f
design/node_pkg.sv
design/node_ram.sv
design/node_fetch.sv
design/node_decode.sv
design/node_execute.sv
design/node_commit.sv
design/node_top.sv
verification/tb_node.sv
